/* compile.f */
isa_pkg.sv
pipe_pkg.sv
id_ex_if.sv
decode_ctrl.sv
reg_file.sv
id_ex_reg.sv
ex_unit.sv
mem_wb_stage.sv
mips_core_top.sv
tb_clk_gen.sv
mips_core_tb.sv

/* decode_ctrl.sv */
`timescale 1ns/1ps

module decode_ctrl import isa_pkg::*, pipe_pkg::*; (
    input  logic     instr_valid,
    input  word_t    instr,
    input  word_t    instr_addr,
    input  logic     redirect_valid,
    input  logic     wb_en,
    input  reg_idx_t wb_reg,
    id_ex_if.decode  id,
    id_ex_if.execute ex,
    output logic     flush_id_ex,
    output fwd_sel_t fwd_a,
    output fwd_sel_t fwd_b,
    output reg_idx_t rs_idx,
    output reg_idx_t rt_idx
);

    opcode_t  opcode;
    funct_t   funct;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;
    word_t    imm_sext;
    word_t    imm_zext;
    logic     known;

    assign opcode   = instr[word_w-1 -: opcode_w];
    assign funct    = instr[funct_w-1:0];
    assign rs       = instr[25:21];
    assign rt       = instr[20:16];
    assign rd       = instr[15:11];
    assign imm_sext = {{(word_w-imm_w){instr[imm_w-1]}}, instr[imm_w-1:0]};
    assign imm_zext = {{(word_w-imm_w){1'b0}}, instr[imm_w-1:0]};

    assign rs_idx = rs;
    assign rt_idx = rt;

    assign id.cur_instaddress  = instr_addr;
    assign id.next_instaddress = instr_addr + word_t'(4);
    assign id.shamt            = instr[10:6];

    // ==================== decode
    always_comb begin
        id.mem_read     = 1'b0;
        id.mem_to_reg   = 1'b0;
        id.alu_op       = alu_add;
        id.mem_write    = 1'b0;
        id.alu_src      = 1'b0;
        id.reg_write    = 1'b0;
        id.equal_branch = 1'b0;
        id.greater_than = 1'b0;
        id.store_pc     = 1'b0;
        id.lui_sig      = 1'b0;
        id.jump         = 1'b0;
        id.imme_num     = imm_sext;
        id.wreg         = rd;
        id.rs           = rs;
        id.rt           = rt;
        known           = 1'b1;
        case (opcode)
            op_rtype: begin
                id.reg_write = 1'b1;
                case (funct)
                    fn_addu: id.alu_op = alu_add;
                    fn_subu: id.alu_op = alu_sub;
                    fn_and:  id.alu_op = alu_and;
                    fn_or:   id.alu_op = alu_or;
                    fn_xor:  id.alu_op = alu_xor;
                    fn_slt:  id.alu_op = alu_slt;
                    fn_sll:  id.alu_op = alu_sll;
                    fn_srl:  id.alu_op = alu_srl;
                    default: known = 1'b0;
                endcase
            end
            op_addiu: begin
                id.alu_src   = 1'b1;
                id.reg_write = 1'b1;
                id.wreg      = rt;
            end
            op_ori: begin
                id.alu_op    = alu_or;
                id.alu_src   = 1'b1;
                id.reg_write = 1'b1;
                id.imme_num  = imm_zext;
                id.wreg      = rt;
            end
            op_lui: begin
                id.alu_op    = alu_lui;
                id.lui_sig   = 1'b1; // picks the immediate in ex
                id.reg_write = 1'b1;
                id.imme_num  = imm_zext;
                id.wreg      = rt;
            end
            op_lw: begin
                id.alu_src    = 1'b1;
                id.mem_read   = 1'b1;
                id.mem_to_reg = 1'b1;
                id.reg_write  = 1'b1;
                id.wreg       = rt;
            end
            op_sw: begin
                id.alu_src   = 1'b1;
                id.mem_write = 1'b1;
            end
            op_beq: begin
                id.alu_op       = alu_sub;
                id.equal_branch = 1'b1;
            end
            op_bgtz: id.greater_than = 1'b1;
            op_jal: begin
                id.alu_op    = alu_pass_b;
                id.jump      = 1'b1;
                id.store_pc  = 1'b1;
                id.reg_write = 1'b1;
                id.imme_num  = {{(word_w-index_w){1'b0}}, instr[index_w-1:0]};
            end
            default: known = 1'b0;
        endcase

        // bubble for idle slots and anything not recognised
        if (!instr_valid || !known) begin
            id.mem_read     = 1'b0;
            id.mem_to_reg   = 1'b0;
            id.alu_op       = alu_add;
            id.mem_write    = 1'b0;
            id.alu_src      = 1'b0;
            id.reg_write    = 1'b0;
            id.equal_branch = 1'b0;
            id.greater_than = 1'b0;
            id.store_pc     = 1'b0;
            id.lui_sig      = 1'b0;
            id.jump         = 1'b0;
            id.wreg         = '0;
            id.rs           = '0;
            id.rt           = '0;
        end
    end

    // ==================== forwarding
    assign fwd_a = (wb_en && wb_reg != '0 && wb_reg == ex.rs) ? fwd_wb : fwd_idex;
    assign fwd_b = (wb_en && wb_reg != '0 && wb_reg == ex.rt) ? fwd_wb : fwd_idex;

    assign flush_id_ex = redirect_valid; // kill the slot behind a redirect

    fwd_known: assert final (!$isunknown({fwd_a, fwd_b}))
        else $error("forwarding select unknown");

endmodule

/* ex_unit.sv */
`timescale 1ns/1ps

module ex_unit import isa_pkg::*, pipe_pkg::*; (
    id_ex_if.execute ex,
    input  fwd_sel_t fwd_a,
    input  fwd_sel_t fwd_b,
    input  word_t    wb_data,
    output logic     redirect_valid,
    output word_t    redirect_addr,
    output word_t    ex_result,
    output word_t    ex_store_data,
    output reg_idx_t ex_wreg,
    output logic     ex_reg_write,
    output logic     ex_mem_read,
    output logic     ex_mem_write
);

    word_t op_a;
    word_t reg_b;
    word_t op_b;
    word_t alu_y;
    word_t br_target;
    word_t jump_target;
    logic  taken;

    // ==================== operands
    assign op_a  = (fwd_a == fwd_wb) ? wb_data : ex.rdata_a;
    assign reg_b = (fwd_b == fwd_wb) ? wb_data : ex.rdata_b;
    assign op_b  = (ex.alu_src || ex.lui_sig) ? ex.imme_num : reg_b;

    // ==================== alu
    always_comb begin
        case (ex.alu_op)
            alu_add: alu_y = op_a + op_b;
            alu_sub: alu_y = op_a - op_b;
            alu_and: alu_y = op_a & op_b;
            alu_or:  alu_y = op_a | op_b;
            alu_xor: alu_y = op_a ^ op_b;
            alu_slt: alu_y = {{(word_w-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sll: alu_y = op_b << ex.shamt;
            alu_srl: alu_y = op_b >> ex.shamt;
            alu_lui: alu_y = {op_b[15:0], 16'h0000};
            default: alu_y = op_b; // pass_b
        endcase
    end

    // ==================== branch / jump
    assign taken = (ex.equal_branch && op_a == reg_b)
                || (ex.greater_than && !op_a[word_w-1] && op_a != '0);

    assign br_target   = ex.cur_instaddress + word_t'(4) + {ex.imme_num[word_w-3:0], 2'b00};
    assign jump_target = {ex.next_instaddress[word_w-1 -: 4], ex.imme_num[index_w-1:0], 2'b00};

    assign redirect_valid = ex.jump || taken;
    assign redirect_addr  = ex.jump ? jump_target : br_target;

    // ==================== to mem/wb
    assign ex_result     = ex.store_pc ? ex.next_instaddress : alu_y; // jal link value
    assign ex_store_data = reg_b;
    assign ex_wreg       = ex.store_pc ? reg_idx_t'(link_reg) : ex.wreg;
    assign ex_reg_write  = ex.reg_write;
    assign ex_mem_read   = ex.mem_read && ex.mem_to_reg; // load into register
    assign ex_mem_write  = ex.mem_write;

    // a redirect comes from exactly one control-flow flag
    redirect_has_cause: assert final (!redirect_valid
                                      || $onehot({ex.equal_branch, ex.greater_than, ex.jump}))
        else $error("redirect without a single branch or jump flag");

endmodule

/* id_ex_if.sv */
`timescale 1ns/1ps

interface id_ex_if import isa_pkg::*, pipe_pkg::*; ();

    // control
    logic     mem_read;
    logic     mem_to_reg;
    alu_op_t  alu_op;
    logic     mem_write;
    logic     alu_src;
    logic     reg_write;
    logic     equal_branch;
    logic     greater_than;
    logic     store_pc;
    logic     lui_sig;
    logic     jump;

    // data
    word_t    next_instaddress;
    word_t    cur_instaddress;
    word_t    rdata_a;
    word_t    rdata_b;
    word_t    imme_num;
    shamt_t   shamt;
    reg_idx_t wreg;
    reg_idx_t rs;
    reg_idx_t rt;

    modport decode (
        output mem_read, mem_to_reg, alu_op, mem_write, alu_src, reg_write,
               equal_branch, greater_than, store_pc, lui_sig, jump,
               next_instaddress, cur_instaddress, rdata_a, rdata_b, imme_num,
               shamt, wreg, rs, rt
    );

    modport stage (
        output mem_read, mem_to_reg, alu_op, mem_write, alu_src, reg_write,
               equal_branch, greater_than, store_pc, lui_sig, jump,
               next_instaddress, cur_instaddress, rdata_a, rdata_b, imme_num,
               shamt, wreg, rs, rt
    );

    modport execute (
        input mem_read, mem_to_reg, alu_op, mem_write, alu_src, reg_write,
              equal_branch, greater_than, store_pc, lui_sig, jump,
              next_instaddress, cur_instaddress, rdata_a, rdata_b, imme_num,
              shamt, wreg, rs, rt
    );

endinterface

/* id_ex_reg.sv */
`timescale 1ns/1ps

module id_ex_reg import isa_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     flush_id_ex,
    id_ex_if.execute id,
    id_ex_if.stage   ex
);

    logic keep;

    assign keep = !flush_id_ex;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex.mem_read         <= 1'b0;
            ex.mem_to_reg       <= 1'b0;
            ex.alu_op           <= alu_add;
            ex.mem_write        <= 1'b0;
            ex.alu_src          <= 1'b0;
            ex.reg_write        <= 1'b0;
            ex.equal_branch     <= 1'b0;
            ex.greater_than     <= 1'b0;
            ex.store_pc         <= 1'b0;
            ex.lui_sig          <= 1'b0;
            ex.jump             <= 1'b0;
            ex.next_instaddress <= '0;
            ex.cur_instaddress  <= '0;
            ex.rdata_a          <= '0;
            ex.rdata_b          <= '0;
            ex.imme_num         <= '0;
            ex.shamt            <= '0;
            ex.wreg             <= '0;
            ex.rs               <= '0;
            ex.rt               <= '0;
        end else begin
            // flush loads an all-zero slot
            ex.mem_read         <= keep ? id.mem_read : 1'b0;
            ex.mem_to_reg       <= keep ? id.mem_to_reg : 1'b0;
            ex.alu_op           <= keep ? id.alu_op : alu_add;
            ex.mem_write        <= keep ? id.mem_write : 1'b0;
            ex.alu_src          <= keep ? id.alu_src : 1'b0;
            ex.reg_write        <= keep ? id.reg_write : 1'b0;
            ex.equal_branch     <= keep ? id.equal_branch : 1'b0;
            ex.greater_than     <= keep ? id.greater_than : 1'b0;
            ex.store_pc         <= keep ? id.store_pc : 1'b0;
            ex.lui_sig          <= keep ? id.lui_sig : 1'b0;
            ex.jump             <= keep ? id.jump : 1'b0;
            ex.next_instaddress <= keep ? id.next_instaddress : '0;
            ex.cur_instaddress  <= keep ? id.cur_instaddress : '0;
            ex.rdata_a          <= keep ? id.rdata_a : '0;
            ex.rdata_b          <= keep ? id.rdata_b : '0;
            ex.imme_num         <= keep ? id.imme_num : '0;
            ex.shamt            <= keep ? id.shamt : '0;
            ex.wreg             <= keep ? id.wreg : '0;
            ex.rs               <= keep ? id.rs : '0;
            ex.rt               <= keep ? id.rt : '0;
        end
    end

    // only a branch or jump held in ex may squash the slot behind it
    flush_from_branch: assert property (@(posedge clk) disable iff (!arst_n)
        flush_id_ex |-> (ex.jump || ex.equal_branch || ex.greater_than))
        else $error("id_ex flush without a branch or jump in ex");

endmodule

/* isa_pkg.sv */
package isa_pkg;

    // instruction field widths
    localparam int opcode_w = 6;
    localparam int funct_w  = 6;
    localparam int shamt_w  = 5;
    localparam int imm_w    = 16;
    localparam int index_w  = 26;

    typedef logic [opcode_w-1:0] opcode_t;
    typedef logic [funct_w-1:0]  funct_t;
    typedef logic [shamt_w-1:0]  shamt_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl,
        alu_lui,
        alu_pass_b
    } alu_op_t;

    // ==================== primary opcodes
    localparam opcode_t op_rtype = 6'h00;
    localparam opcode_t op_jal   = 6'h03;
    localparam opcode_t op_beq   = 6'h04;
    localparam opcode_t op_bgtz  = 6'h07;
    localparam opcode_t op_addiu = 6'h09;
    localparam opcode_t op_ori   = 6'h0d;
    localparam opcode_t op_lui   = 6'h0f;
    localparam opcode_t op_lw    = 6'h23;
    localparam opcode_t op_sw    = 6'h2b;

    // ==================== r-type funct
    localparam funct_t fn_sll  = 6'h00;
    localparam funct_t fn_srl  = 6'h02;
    localparam funct_t fn_addu = 6'h21;
    localparam funct_t fn_subu = 6'h23;
    localparam funct_t fn_and  = 6'h24;
    localparam funct_t fn_or   = 6'h25;
    localparam funct_t fn_xor  = 6'h26;
    localparam funct_t fn_slt  = 6'h2a;

    localparam logic [4:0] link_reg = 5'd31; // jal destination

endpackage

/* mem_wb_stage.sv */
`timescale 1ns/1ps

module mem_wb_stage import pipe_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  word_t    ex_result,
    input  word_t    ex_store_data,
    input  reg_idx_t ex_wreg,
    input  logic     ex_reg_write,
    input  logic     ex_mem_read,
    input  logic     ex_mem_write,
    output logic     wb_en,
    output reg_idx_t wb_reg,
    output word_t    wb_data
);

    word_t              dmem [dmem_depth];
    word_t              result_q;
    word_t              store_q;
    reg_idx_t           wreg_q;
    logic               reg_write_q;
    logic               mem_read_q;
    logic               mem_write_q;
    logic [dmem_aw-1:0] dmem_idx;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reg_write_q <= 1'b0;
            mem_read_q  <= 1'b0;
            mem_write_q <= 1'b0;
        end else begin
            reg_write_q <= ex_reg_write;
            mem_read_q  <= ex_mem_read;
            mem_write_q <= ex_mem_write;
        end
    end

    always_ff @(posedge clk) begin
        result_q <= ex_result;
        store_q  <= ex_store_data;
        wreg_q   <= ex_wreg;
    end

    assign dmem_idx = result_q[dmem_aw+1:2]; // word address

    // ==================== data memory
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < dmem_depth; i++) begin
                dmem[i] <= '0;
            end
        end else if (mem_write_q) begin
            dmem[dmem_idx] <= store_q;
        end
    end

    assign wb_en   = reg_write_q && wreg_q != '0;
    assign wb_reg  = wreg_q;
    assign wb_data = mem_read_q ? dmem[dmem_idx] : result_q;

endmodule

/* mips_core_tb.sv */
`timescale 1ns/1ps

module mips_core_tb import isa_pkg::*, pipe_pkg::*; ();

    localparam int clk_period = 40;
    localparam int n_random   = 400;

    logic     clk;
    logic     arst_n;
    logic     instr_valid;
    word_t    instr;
    word_t    instr_addr;
    logic     redirect_valid;
    word_t    redirect_addr;
    logic     wb_en;
    reg_idx_t wb_reg;
    word_t    wb_data;

    // reference machine
    word_t    model_regs [num_regs];
    word_t    model_mem [dmem_depth];
    word_t    pc;
    word_t    saved_target;
    logic     squash_next;
    logic     prog_valid [$];
    word_t    prog_word [$];
    int       wb_expected;
    int       redirect_expected;
    int       wb_seen;
    int       redirect_seen;

    // expected outputs, staged to the pipeline depth
    logic     nxt_rd_v;
    word_t    nxt_rd_a;
    logic     nxt_wb_en;
    reg_idx_t nxt_wb_reg;
    word_t    nxt_wb_data;
    logic     exp_rd_v;
    word_t    exp_rd_a;
    logic     mid_wb_en;
    reg_idx_t mid_wb_reg;
    word_t    mid_wb_data;
    logic     exp_wb_en;
    reg_idx_t exp_wb_reg;
    word_t    exp_wb_data;

    tb_clk_gen clk_gen_inst (
        .clk    (clk),
        .arst_n (arst_n)
    );

    mips_core_top mips_core_top_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .instr_addr     (instr_addr),
        .redirect_valid (redirect_valid),
        .redirect_addr  (redirect_addr),
        .wb_en          (wb_en),
        .wb_reg         (wb_reg),
        .wb_data        (wb_data)
    );

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exp_rd_v    <= 1'b0;
            exp_rd_a    <= '0;
            mid_wb_en   <= 1'b0;
            mid_wb_reg  <= '0;
            mid_wb_data <= '0;
            exp_wb_en   <= 1'b0;
            exp_wb_reg  <= '0;
            exp_wb_data <= '0;
        end else begin
            exp_rd_v    <= nxt_rd_v; // redirect shows one cycle after issue
            exp_rd_a    <= nxt_rd_a;
            mid_wb_en   <= nxt_wb_en;
            mid_wb_reg  <= nxt_wb_reg;
            mid_wb_data <= nxt_wb_data;
            exp_wb_en   <= mid_wb_en; // writeback two edges after issue
            exp_wb_reg  <= mid_wb_reg;
            exp_wb_data <= mid_wb_data;
        end
    end

    always @(negedge clk) begin
        if (arst_n && wb_en) wb_seen++;
        if (arst_n && redirect_valid) redirect_seen++;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic value_mismatch(input string name, input word_t expected, input word_t actual);
        fail_run($sformatf("Fail at %0t ns: %s expected 0x%h, actual 0x%h",
                           $time, name, expected, actual));
    endtask

    task automatic watchdog(input int cycles);
        #(cycles * clk_period);
        fail_run($sformatf("timeout: the run did not finish within %0d clock cycles", cycles));
    endtask

    // ==================== checks
    redirect_flag: assert property (@(posedge clk) disable iff (!arst_n)
        redirect_valid == exp_rd_v)
        else value_mismatch("redirect_valid", $sampled(exp_rd_v), $sampled(redirect_valid));
    redirect_target: assert property (@(posedge clk) disable iff (!arst_n)
        exp_rd_v |-> redirect_addr == exp_rd_a)
        else value_mismatch("redirect_addr", $sampled(exp_rd_a), $sampled(redirect_addr));
    wb_enable: assert property (@(posedge clk) disable iff (!arst_n)
        wb_en == exp_wb_en)
        else value_mismatch("wb_en", $sampled(exp_wb_en), $sampled(wb_en));
    wb_dest: assert property (@(posedge clk) disable iff (!arst_n)
        exp_wb_en |-> wb_reg == exp_wb_reg)
        else value_mismatch("wb_reg", $sampled(exp_wb_reg), $sampled(wb_reg));
    wb_value: assert property (@(posedge clk) disable iff (!arst_n)
        exp_wb_en |-> wb_data == exp_wb_data)
        else value_mismatch("wb_data", $sampled(exp_wb_data), $sampled(wb_data));

    // ==================== encoding
    function automatic word_t rtype_word(input reg_idx_t rs, input reg_idx_t rt,
                                         input reg_idx_t rd, input shamt_t sh, input funct_t fn);
        return {op_rtype, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t itype_word(input opcode_t op, input reg_idx_t rs,
                                         input reg_idx_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t jal_word(input logic [25:0] index);
        return {op_jal, index};
    endfunction

    task automatic append_slot(input logic valid, input word_t w);
        prog_valid.push_back(valid);
        prog_word.push_back(w);
    endtask

    // executes one slot on the reference machine, then drives it
    task automatic issue_slot(input logic valid, input word_t w);
        word_t    a;
        word_t    b;
        word_t    simm;
        word_t    link;
        word_t    addr;
        word_t    this_pc;
        logic     squashed;
        logic     wr_en;
        reg_idx_t wr_reg;
        word_t    wr_val;
        logic     taken;
        word_t    target;
        a        = model_regs[w[25:21]];
        b        = model_regs[w[20:16]];
        simm     = {{16{w[15]}}, w[15:0]};
        addr     = a + simm;
        this_pc  = pc;
        link     = pc + 32'd4;
        squashed = squash_next;
        wr_en    = 1'b0;
        wr_reg   = w[20:16];
        wr_val   = '0;
        taken    = 1'b0;
        target   = link + (simm << 2);
        if (valid && !squashed) begin
            wr_en = 1'b1;
            case (w[31:26])
                op_rtype: begin
                    wr_reg = w[15:11];
                    case (w[5:0])
                        fn_addu: wr_val = a + b;
                        fn_subu: wr_val = a - b;
                        fn_and:  wr_val = a & b;
                        fn_or:   wr_val = a | b;
                        fn_xor:  wr_val = a ^ b;
                        fn_slt:  wr_val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        fn_sll:  wr_val = b << w[10:6];
                        fn_srl:  wr_val = b >> w[10:6];
                        default: wr_en = 1'b0;
                    endcase
                end
                op_addiu: wr_val = a + simm;
                op_ori:   wr_val = a | {16'h0000, w[15:0]};
                op_lui:   wr_val = {w[15:0], 16'h0000};
                op_lw:    wr_val = model_mem[addr[7:2]];
                op_sw: begin
                    model_mem[addr[7:2]] = b;
                    wr_en = 1'b0;
                end
                op_beq: begin
                    taken = (a == b);
                    wr_en = 1'b0;
                end
                op_bgtz: begin
                    taken = ($signed(a) > 0);
                    wr_en = 1'b0;
                end
                op_jal: begin
                    taken  = 1'b1;
                    target = {link[31:28], w[25:0], 2'b00};
                    wr_reg = link_reg;
                    wr_val = link;
                end
                default: wr_en = 1'b0;
            endcase
        end
        if (wr_en && wr_reg != '0) model_regs[wr_reg] = wr_val;

        squash_next = 1'b0;
        if (squashed) begin
            pc = saved_target;
        end else if (taken) begin
            squash_next  = 1'b1;
            saved_target = target;
            pc           = link; // fall-through slot goes out first
        end else if (valid) begin
            pc = link;
        end

        @(negedge clk);
        instr_valid = valid;
        instr       = w;
        instr_addr  = this_pc;
        nxt_rd_v    = taken;
        nxt_rd_a    = target;
        nxt_wb_en   = wr_en && wr_reg != '0;
        nxt_wb_reg  = wr_reg;
        nxt_wb_data = wr_val;
        wb_expected       += int'(nxt_wb_en);
        redirect_expected += int'(taken);
    endtask

    task automatic issue_random();
        reg_idx_t    rs;
        reg_idx_t    rt;
        reg_idx_t    rd;
        logic [15:0] imm;
        word_t       w;
        rs  = reg_idx_t'($urandom_range(7)); // r0..r7 keeps hazards frequent
        rt  = reg_idx_t'($urandom_range(7));
        rd  = reg_idx_t'($urandom_range(7));
        imm = 16'($urandom);
        case ($urandom_range(15))
            0:       w = rtype_word(rs, rt, rd, 5'd0, fn_addu);
            1:       w = rtype_word(rs, rt, rd, 5'd0, fn_subu);
            2:       w = rtype_word(rs, rt, rd, 5'd0, fn_and);
            3:       w = rtype_word(rs, rt, rd, 5'd0, fn_or);
            4:       w = rtype_word(rs, rt, rd, 5'd0, fn_xor);
            5:       w = rtype_word(rs, rt, rd, 5'd0, fn_slt);
            6:       w = rtype_word(5'd0, rt, rd, shamt_t'($urandom), fn_sll);
            7:       w = rtype_word(5'd0, rt, rd, shamt_t'($urandom), fn_srl);
            8:       w = itype_word(op_addiu, rs, rt, imm);
            9:       w = itype_word(op_ori, rs, rt, imm);
            10:      w = itype_word(op_lui, 5'd0, rt, imm);
            11:      w = itype_word(op_lw, rs, rt, imm);
            12:      w = itype_word(op_sw, rs, rt, imm);
            13:      w = itype_word(op_beq, rs, ($urandom_range(1) != 0) ? rs : rt, imm);
            14:      w = itype_word(op_bgtz, rs, 5'd0, imm);
            default: w = jal_word(26'($urandom));
        endcase
        issue_slot($urandom_range(9) != 0, w);
    endtask

    // ==================== directed prologue
    task automatic build_prologue();
        repeat (3) append_slot(1'b0, '0); // idle after reset
        append_slot(1'b1, itype_word(op_addiu, 5'd0, 5'd1, 16'h1234));
        append_slot(1'b1, itype_word(op_addiu, 5'd1, 5'd2, 16'hffff)); // forwarded
        append_slot(1'b1, itype_word(op_lui, 5'd0, 5'd3, 16'hdead));
        append_slot(1'b1, itype_word(op_ori, 5'd3, 5'd3, 16'hbeef));
        append_slot(1'b1, rtype_word(5'd1, 5'd2, 5'd4, 5'd0, fn_addu)); // write-through
        append_slot(1'b1, rtype_word(5'd4, 5'd3, 5'd5, 5'd0, fn_subu));
        append_slot(1'b1, rtype_word(5'd5, 5'd1, 5'd6, 5'd0, fn_and));
        append_slot(1'b1, rtype_word(5'd5, 5'd1, 5'd6, 5'd0, fn_or));
        append_slot(1'b1, rtype_word(5'd6, 5'd3, 5'd7, 5'd0, fn_xor));
        append_slot(1'b1, rtype_word(5'd3, 5'd1, 5'd6, 5'd0, fn_slt));
        append_slot(1'b1, rtype_word(5'd0, 5'd3, 5'd7, 5'd4, fn_sll));
        append_slot(1'b1, rtype_word(5'd0, 5'd7, 5'd7, 5'd8, fn_srl));
        append_slot(1'b1, itype_word(op_addiu, 5'd1, 5'd0, 16'h0005)); // r0 stays zero
        append_slot(1'b1, rtype_word(5'd1, 5'd2, 5'd0, 5'd0, fn_addu));
        append_slot(1'b1, itype_word(op_sw, 5'd0, 5'd3, 16'h0010));
        append_slot(1'b1, itype_word(op_lw, 5'd0, 5'd6, 16'h0010));
        append_slot(1'b1, rtype_word(5'd6, 5'd1, 5'd7, 5'd0, fn_addu)); // load-use
        append_slot(1'b1, itype_word(op_sw, 5'd1, 5'd4, 16'hfffc));
        append_slot(1'b1, itype_word(op_lw, 5'd1, 5'd5, 16'hfffc));
        append_slot(1'b1, itype_word(op_beq, 5'd1, 5'd1, 16'h0003)); // taken
        append_slot(1'b1, itype_word(op_addiu, 5'd0, 5'd2, 16'h0063));
        append_slot(1'b1, itype_word(op_beq, 5'd1, 5'd2, 16'h0003)); // not taken
        append_slot(1'b1, itype_word(op_addiu, 5'd0, 5'd2, 16'h0007));
        append_slot(1'b1, itype_word(op_bgtz, 5'd1, 5'd0, 16'hfffe));
        append_slot(1'b1, itype_word(op_addiu, 5'd0, 5'd3, 16'h0001));
        append_slot(1'b1, itype_word(op_addiu, 5'd0, 5'd5, 16'hfff8));
        append_slot(1'b1, itype_word(op_bgtz, 5'd5, 5'd0, 16'h0004)); // negative operand
        append_slot(1'b1, itype_word(op_addiu, 5'd0, 5'd4, 16'h0002));
        append_slot(1'b1, jal_word(26'h0000010));
        append_slot(1'b1, rtype_word(5'd1, 5'd1, 5'd1, 5'd0, fn_addu));
        append_slot(1'b1, rtype_word(5'd31, 5'd0, 5'd4, 5'd0, fn_addu)); // link readback
        repeat (2) append_slot(1'b0, '0);
    endtask

    initial begin
        void'($urandom(32'hc4f1));
        instr_valid       = 1'b0;
        instr             = '0;
        instr_addr        = '0;
        nxt_rd_v          = 1'b0;
        nxt_rd_a          = '0;
        nxt_wb_en         = 1'b0;
        nxt_wb_reg        = '0;
        nxt_wb_data       = '0;
        pc                = 32'h0000_1000;
        saved_target      = '0;
        squash_next       = 1'b0;
        wb_expected       = 0;
        redirect_expected = 0;
        for (int i = 0; i < num_regs; i++) model_regs[i] = '0;
        for (int i = 0; i < dmem_depth; i++) model_mem[i] = '0;
        build_prologue();
        fork
            watchdog(prog_word.size() + n_random + 20);
        join_none

        @(posedge arst_n);
        @(posedge clk);
        foreach (prog_word[i]) issue_slot(prog_valid[i], prog_word[i]);
        repeat (n_random) issue_random();
        repeat (4) issue_slot(1'b0, '0); // drain
        @(negedge clk);

        if (wb_seen != wb_expected || redirect_seen != redirect_expected) begin
            fail_run($sformatf("count mismatch: %0d of %0d writebacks, %0d of %0d redirects",
                               wb_seen, wb_expected, redirect_seen, redirect_expected));
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

/* mips_core_top.sv */
`timescale 1ns/1ps

module mips_core_top import pipe_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     instr_valid,
    input  word_t    instr,
    input  word_t    instr_addr,
    output logic     redirect_valid,
    output word_t    redirect_addr,
    output logic     wb_en,
    output reg_idx_t wb_reg,
    output word_t    wb_data
);

    logic     flush_id_ex;
    fwd_sel_t fwd_a;
    fwd_sel_t fwd_b;
    reg_idx_t rs_idx;
    reg_idx_t rt_idx;
    word_t    ex_result;
    word_t    ex_store_data;
    reg_idx_t ex_wreg;
    logic     ex_reg_write;
    logic     ex_mem_read;
    logic     ex_mem_write;

    id_ex_if id_bus ();
    id_ex_if ex_bus ();

    decode_ctrl decode_ctrl_inst (
        .instr_valid    (instr_valid),
        .instr          (instr),
        .instr_addr     (instr_addr),
        .redirect_valid (redirect_valid),
        .wb_en          (wb_en),
        .wb_reg         (wb_reg),
        .id             (id_bus),
        .ex             (ex_bus),
        .flush_id_ex    (flush_id_ex),
        .fwd_a          (fwd_a),
        .fwd_b          (fwd_b),
        .rs_idx         (rs_idx),
        .rt_idx         (rt_idx)
    );

    reg_file reg_file_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs_idx  (rs_idx),
        .rt_idx  (rt_idx),
        .wb_en   (wb_en),
        .wb_reg  (wb_reg),
        .wb_data (wb_data),
        .id      (id_bus)
    );

    id_ex_reg id_ex_reg_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .flush_id_ex (flush_id_ex),
        .id          (id_bus),
        .ex          (ex_bus)
    );

    ex_unit ex_unit_inst (
        .ex             (ex_bus),
        .fwd_a          (fwd_a),
        .fwd_b          (fwd_b),
        .wb_data        (wb_data),
        .redirect_valid (redirect_valid),
        .redirect_addr  (redirect_addr),
        .ex_result      (ex_result),
        .ex_store_data  (ex_store_data),
        .ex_wreg        (ex_wreg),
        .ex_reg_write   (ex_reg_write),
        .ex_mem_read    (ex_mem_read),
        .ex_mem_write   (ex_mem_write)
    );

    mem_wb_stage mem_wb_stage_inst (
        .clk           (clk),
        .arst_n        (arst_n),
        .ex_result     (ex_result),
        .ex_store_data (ex_store_data),
        .ex_wreg       (ex_wreg),
        .ex_reg_write  (ex_reg_write),
        .ex_mem_read   (ex_mem_read),
        .ex_mem_write  (ex_mem_write),
        .wb_en         (wb_en),
        .wb_reg        (wb_reg),
        .wb_data       (wb_data)
    );

endmodule

/* pipe_pkg.sv */
package pipe_pkg;

    localparam int word_w     = 32;
    localparam int reg_idx_w  = 5;
    localparam int num_regs   = 32;
    localparam int dmem_depth = 64;
    localparam int dmem_aw    = $clog2(dmem_depth);

    typedef logic [word_w-1:0]    word_t;
    typedef logic [reg_idx_w-1:0] reg_idx_t;

    // operand source in ex
    typedef enum logic {
        fwd_idex,
        fwd_wb
    } fwd_sel_t;

endpackage

/* reg_file.sv */
`timescale 1ns/1ps

module reg_file import pipe_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    input  logic     wb_en,
    input  reg_idx_t wb_reg,
    input  word_t    wb_data,
    id_ex_if.decode  id
);

    word_t regs [num_regs];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_reg != '0) begin
            regs[wb_reg] <= wb_data;
        end
    end

    // r0 reads zero, same-cycle write passes straight through
    always_comb begin
        if (rs_idx == '0) id.rdata_a = '0;
        else if (wb_en && wb_reg == rs_idx) id.rdata_a = wb_data;
        else id.rdata_a = regs[rs_idx];
    end

    always_comb begin
        if (rt_idx == '0) id.rdata_b = '0;
        else if (wb_en && wb_reg == rt_idx) id.rdata_b = wb_data;
        else id.rdata_b = regs[rt_idx];
    end

endmodule

/* tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic arst_n
);

    localparam int period       = 40;
    localparam int reset_cycles = 10;

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        #(period * reset_cycles);
        arst_n = 1'b1; // lands on a falling edge
    end

endmodule
